/* src/fetch_cfg.svh */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// program memory depth in 32-bit words
`define FETCH_ROM_WORDS 64

// byte address width seen by the memory, two bits above the word index
`define FETCH_ADDR_BITS 8

`endif

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // standard 32-bit field layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rv_fields_t;

    // the same word seen as two half-word parcels
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } rv_parcels_t;

    typedef union packed {
        rv_fields_t  f;
        rv_parcels_t p;
    } rv_instr_t;

    // what fetch needs to know to steer the PC
    typedef enum logic [1:0] {
        OTHER,
        BRANCH,
        JAL
    } instr_class_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        rv_instr_t   instr;
        logic        compressed;
        logic        decompress_failed;
        logic        is_branch;
    } fetch_packet_t;

endpackage

`default_nettype wire

/* src/instr_rom.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module instr_rom import fetch_pkg::*; (
    input  logic                        clk,
    input  logic                        load_en,
    input  logic [`FETCH_ADDR_BITS-1:0] load_addr,
    input  logic [31:0]                 load_data,
    input  logic [31:0]                 address,
    output rv_instr_t                   data
);

    logic [31:0] mem [`FETCH_ROM_WORDS];

    // program load, only used while the core is held in reset
    always_ff @(posedge clk) begin
        if (load_en)
            mem[load_addr[`FETCH_ADDR_BITS-1:2]] <= load_data;
    end

    // word read, byte offset is dropped
    assign data = mem[address[`FETCH_ADDR_BITS-1:2]];

endmodule

`default_nettype wire

/* src/instr_decompressor.sv */
`timescale 1ns/10ps
`default_nettype none

module instr_decompressor import fetch_pkg::*; (
    input  logic [15:0] c_instr,
    input  logic        is_compressed,
    output rv_instr_t   decompressed_instr,
    output logic        decompress_failed
);

    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [31:0] EBREAK   = 32'h00100073;

    logic [4:0]  rd_full, rs2_full, rd_p, rs1_p;
    logic [2:0]  alu_f3;
    logic [11:0] imm_ci, imm_ciw, imm_cl, imm_lwsp, imm_swsp, imm_16sp;
    logic [12:0] imm_cb;
    logic [20:0] imm_cj;
    logic [31:0] expanded;
    logic        illegal;

    // rd' and rs2' share bits 4:2, both map onto x8..x15
    assign rd_full  = c_instr[11:7];
    assign rs2_full = c_instr[6:2];
    assign rd_p     = {2'b01, c_instr[4:2]};
    assign rs1_p    = {2'b01, c_instr[9:7]};
    // sub, xor, or, and
    assign alu_f3   = (c_instr[6:5] == 2'b00) ? 3'b000 : {1'b1, c_instr[6], &c_instr[6:5]};

    // immediate unscrambling per format
    assign imm_ci   = {{7{c_instr[12]}}, c_instr[6:2]};
    assign imm_ciw  = {2'b00, c_instr[10:7], c_instr[12:11], c_instr[5], c_instr[6], 2'b00};
    assign imm_cl   = {5'b0, c_instr[5], c_instr[12:10], c_instr[6], 2'b00};
    assign imm_lwsp = {4'b0, c_instr[3:2], c_instr[12], c_instr[6:4], 2'b00};
    assign imm_swsp = {4'b0, c_instr[8:7], c_instr[12:9], 2'b00};
    assign imm_16sp = {{3{c_instr[12]}}, c_instr[4:3], c_instr[5], c_instr[2], c_instr[6], 4'b0};
    assign imm_cb   = {{5{c_instr[12]}}, c_instr[6:5], c_instr[2], c_instr[11:10],
                       c_instr[4:3], 1'b0};
    assign imm_cj   = {{10{c_instr[12]}}, c_instr[8], c_instr[10:9], c_instr[6], c_instr[7],
                       c_instr[2], c_instr[11], c_instr[5:3], 1'b0};

    always_comb begin
        expanded = '0;
        illegal  = 1'b0;
        case ({c_instr[1:0], c_instr[15:13]})
            // c.addi4spn, a zero immediate also catches the all-zero parcel
            5'b00_000: begin
                expanded = {imm_ciw, 5'd2, 3'b000, rd_p, OP_IMM};
                illegal  = (c_instr[12:5] == 8'd0);
            end
            5'b00_010: expanded = {imm_cl, rs1_p, 3'b010, rd_p, OP_LOAD};
            5'b00_110: expanded = {imm_cl[11:5], rd_p, rs1_p, 3'b010, imm_cl[4:0], OP_STORE};
            5'b01_000: expanded = {imm_ci, rd_full, 3'b000, rd_full, OP_IMM};
            5'b01_001: expanded = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12], 5'd1, OP_JAL};
            5'b01_010: expanded = {imm_ci, 5'd0, 3'b000, rd_full, OP_IMM};
            // c.addi16sp when rd is sp, c.lui otherwise
            5'b01_011: begin
                if (rd_full == 5'd2)
                    expanded = {imm_16sp, 5'd2, 3'b000, 5'd2, OP_IMM};
                else
                    expanded = {{8{c_instr[12]}}, imm_ci, rd_full, OP_LUI};
                illegal = !c_instr[12] && (c_instr[6:2] == 5'd0);
            end
            5'b01_100: begin
                case (c_instr[11:10])
                    2'b00:   expanded = {7'b0000000, rs2_full, rs1_p, 3'b101, rs1_p, OP_IMM};
                    2'b01:   expanded = {7'b0100000, rs2_full, rs1_p, 3'b101, rs1_p, OP_IMM};
                    2'b10:   expanded = {imm_ci, rs1_p, 3'b111, rs1_p, OP_IMM};
                    default: expanded = {c_instr[6:5] == 2'b00 ? 7'b0100000 : 7'b0000000,
                                         rd_p, rs1_p, alu_f3, rs1_p, OP_REG};
                endcase
                // bit 12 selects RV64-only forms here, except for c.andi
                illegal = c_instr[12] && (c_instr[11:10] != 2'b10);
            end
            5'b01_101: expanded = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12], 5'd0, OP_JAL};
            5'b01_110: expanded = {imm_cb[12], imm_cb[10:5], 5'd0, rs1_p, 3'b000,
                                   imm_cb[4:1], imm_cb[11], OP_BRANCH};
            5'b01_111: expanded = {imm_cb[12], imm_cb[10:5], 5'd0, rs1_p, 3'b001,
                                   imm_cb[4:1], imm_cb[11], OP_BRANCH};
            5'b10_000: begin
                expanded = {7'b0000000, rs2_full, rd_full, 3'b001, rd_full, OP_IMM};
                illegal  = c_instr[12];
            end
            5'b10_010: begin
                expanded = {imm_lwsp, 5'd2, 3'b010, rd_full, OP_LOAD};
                illegal  = (rd_full == 5'd0);
            end
            // c.jr, c.mv, c.ebreak, c.jalr, c.add
            5'b10_100: begin
                if (!c_instr[12] && rs2_full == 5'd0) begin
                    expanded = {12'd0, rd_full, 3'b000, 5'd0, OP_JALR};
                    illegal  = (rd_full == 5'd0);
                end else if (!c_instr[12])
                    expanded = {7'b0000000, rs2_full, 5'd0, 3'b000, rd_full, OP_REG};
                else if (rs2_full == 5'd0)
                    expanded = (rd_full == 5'd0) ? EBREAK : {12'd0, rd_full, 3'b000, 5'd1, OP_JALR};
                else
                    expanded = {7'b0000000, rs2_full, rd_full, 3'b000, rd_full, OP_REG};
            end
            5'b10_110: expanded = {imm_swsp[11:5], rs2_full, 5'd2, 3'b010, imm_swsp[4:0], OP_STORE};
            // floating-point loads and stores, reserved slots
            default:   illegal = 1'b1;
        endcase
    end

    assign decompressed_instr = expanded;
    assign decompress_failed  = is_compressed & illegal;

endmodule

`default_nettype wire

/* src/fetch_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import fetch_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  rv_instr_t     data,
    input  logic          pc_write,
    input  logic          prediction,
    input  logic          pc_src,
    input  logic          jalr_flag,
    input  logic [31:0]   jalr_target,
    input  rv_instr_t     decompressed_instr,
    input  logic          decompress_failed,
    output logic [31:0]   address,
    output logic [15:0]   c_instr,
    output logic          is_compressed,
    output fetch_packet_t packet,
    output logic          if_id_flush,
    output logic          id_ex_flush
);

    typedef enum logic {
        DIRECT,
        USE_BUFFER
    } align_state_t;

    // a conditional branch still waiting for its outcome
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] offset;
        logic        compressed;
        logic        pred;
    } branch_hist_t;

    align_state_t state, state_next;
    logic [15:0]  instr_buffer, buffer_next;
    logic [31:0]  pc_reg, pc_next, pc_seq, recovery;
    logic [31:0]  b_offset, j_offset;
    logic         run, step, align_wait, mispredict, flush, redirect;
    rv_instr_t    raw_instr, instr;
    instr_class_t instr_class;
    branch_hist_t hist0, hist1, hist_new;

    // half-word aligner
    always_comb begin
        state_next    = DIRECT;
        buffer_next   = instr_buffer;
        raw_instr     = data;
        c_instr       = data.p.lo;
        is_compressed = 1'b0;
        align_wait    = 1'b0;
        case (state)
            DIRECT: begin
                if (!pc_reg[1]) begin
                    if (data.p.lo[1:0] != 2'b11) begin
                        is_compressed = 1'b1;
                        // standard instruction starts in the upper half, keep it
                        if (data.p.hi[1:0] == 2'b11) begin
                            state_next  = USE_BUFFER;
                            buffer_next = data.p.hi;
                        end
                    end
                end else if (data.p.hi[1:0] != 2'b11) begin
                    c_instr       = data.p.hi;
                    is_compressed = 1'b1;
                end else begin
                    // jumped onto the first half of a straddling instruction
                    align_wait  = 1'b1;
                    state_next  = USE_BUFFER;
                    buffer_next = data.p.hi;
                end
            end
            USE_BUFFER: begin
                raw_instr.p.hi = data.p.lo;
                raw_instr.p.lo = instr_buffer;
                if (data.p.hi[1:0] == 2'b11) begin
                    state_next  = USE_BUFFER;
                    buffer_next = data.p.hi;
                end
            end
        endcase
    end

    // buffered half sits at pc, so the word to read is one further on
    assign address = (state == USE_BUFFER) ? pc_reg + 32'd2 : pc_reg;
    assign instr   = is_compressed ? decompressed_instr : raw_instr;

    always_comb begin
        instr_class = OTHER;
        if (!align_wait && !flush) begin
            case (instr.f.opcode)
                7'b1100011: instr_class = BRANCH;
                7'b1101111: instr_class = JAL;
                default:    instr_class = OTHER;
            endcase
        end
    end

    assign b_offset = {{20{instr.f.funct7[6]}}, instr.f.rd[0], instr.f.funct7[5:0],
                       instr.f.rd[4:1], 1'b0};
    assign j_offset = {{12{instr.f.funct7[6]}}, instr.f.rs1, instr.f.funct3, instr.f.rs2[0],
                       instr.f.funct7[5:0], instr.f.rs2[4:1], 1'b0};

    // resolution of the branch two slots back
    assign step       = run & pc_write;
    assign mispredict = hist1.valid & (pc_src != hist1.pred);
    assign flush      = step & (jalr_flag | mispredict);
    assign recovery   = hist1.pred ? hist1.pc + (hist1.compressed ? 32'd2 : 32'd4)
                                   : hist1.pc + hist1.offset;
    assign pc_seq     = pc_reg + (is_compressed ? 32'd2 : 32'd4);
    assign redirect   = flush | (instr_class == JAL) | (instr_class == BRANCH && prediction);

    always_comb begin
        if (jalr_flag)
            pc_next = jalr_target;
        else if (mispredict)
            pc_next = recovery;
        else if (align_wait)
            pc_next = pc_reg;
        else if (instr_class == JAL)
            pc_next = pc_reg + j_offset;
        else if (instr_class == BRANCH && prediction)
            pc_next = pc_reg + b_offset;
        else
            pc_next = pc_seq;
    end

    always_comb begin
        hist_new.valid      = (instr_class == BRANCH);
        hist_new.pc         = pc_reg;
        hist_new.offset     = b_offset;
        hist_new.compressed = is_compressed;
        hist_new.pred       = prediction;
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            run    <= 1'b0;
            pc_reg <= '0;
            state  <= DIRECT;
            hist0  <= '0;
            hist1  <= '0;
        end else begin
            run <= 1'b1;
            if (step) begin
                pc_reg <= pc_next;
                // a redirect throws away the sequential half-word
                state  <= redirect ? DIRECT : state_next;
                hist0  <= hist_new;
                hist1  <= flush ? '0 : hist0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step)
            instr_buffer <= buffer_next;
    end

    always_comb begin
        packet.valid             = step & !flush & !align_wait;
        packet.pc                = pc_reg;
        packet.instr             = instr;
        packet.compressed        = is_compressed;
        packet.decompress_failed = decompress_failed;
        packet.is_branch         = (instr_class == BRANCH);
    end

    // the wrong-path slot in decode dies along with the one in fetch
    assign if_id_flush = flush;
    assign id_ex_flush = flush;

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_top import fetch_pkg::*; (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        load_en,
    input  logic [`FETCH_ADDR_BITS-1:0] load_addr,
    input  logic [31:0]                 load_data,
    input  logic                        pc_write,
    input  logic                        prediction,
    input  logic                        pc_src,
    input  logic                        jalr_flag,
    input  logic [31:0]                 jalr_target,
    output fetch_packet_t               packet,
    output logic                        if_id_flush
);

    rv_instr_t   rom_data;
    rv_instr_t   decompressed_instr;
    logic [31:0] address;
    logic [15:0] c_instr;
    logic        is_compressed;
    logic        decompress_failed;

    instr_rom rom (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .address   (address),
        .data      (rom_data)
    );

    // no execute stage here, so the second flush has no consumer
    fetch_stage fetch (
        .clk                (clk),
        .reset_n            (reset_n),
        .data               (rom_data),
        .pc_write           (pc_write),
        .prediction         (prediction),
        .pc_src             (pc_src),
        .jalr_flag          (jalr_flag),
        .jalr_target        (jalr_target),
        .decompressed_instr (decompressed_instr),
        .decompress_failed  (decompress_failed),
        .address            (address),
        .c_instr            (c_instr),
        .is_compressed      (is_compressed),
        .packet             (packet),
        .if_id_flush        (if_id_flush),
        .id_ex_flush        ()
    );

    instr_decompressor decompressor (
        .c_instr            (c_instr),
        .is_compressed      (is_compressed),
        .decompressed_instr (decompressed_instr),
        .decompress_failed  (decompress_failed)
    );

endmodule

`default_nettype wire

/* tb/fetch_tb.sv */
`timescale 1ns/10ps
`default_nettype none
`include "fetch_cfg.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int NUM_ROWS       = 18;
    localparam int PROG_WORDS     = 14;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = PROG_WORDS + RESET_CYCLES + NUM_ROWS * 3 + 20;

    // one fetch cycle of stimulus and the packet it should give
    typedef struct packed {
        logic [2:0]  ctrl;
        logic [31:0] jalr_target;
        logic [31:0] pc;
        rv_instr_t   instr;
        logic [4:0]  flags;
    } step_t;

    logic                        clk;
    logic                        reset_n;
    logic                        load_en;
    logic [`FETCH_ADDR_BITS-1:0] load_addr;
    logic [31:0]                 load_data;
    logic                        pc_write;
    logic                        prediction;
    logic                        pc_src;
    logic                        jalr_flag;
    logic [31:0]                 jalr_target;
    fetch_packet_t               packet;
    logic                        if_id_flush;

    step_t       steps [NUM_ROWS];
    string       names [NUM_ROWS];
    int          row_count   = 0;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    fetch_top dut (
        .clk         (clk),
        .reset_n     (reset_n),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .pc_write    (pc_write),
        .prediction  (prediction),
        .pc_src      (pc_src),
        .jalr_flag   (jalr_flag),
        .jalr_target (jalr_target),
        .packet      (packet),
        .if_id_flush (if_id_flush)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the fetch sequence did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    // ctrl is {prediction, pc_src, jalr_flag}
    // flags is {is_branch, compressed, decompress_failed, valid, if_id_flush}
    task automatic add_row(input string name, input logic [2:0] ctrl, input logic [31:0] target,
                           input logic [31:0] pc, input logic [31:0] instr,
                           input logic [4:0] flags);
        steps[row_count].ctrl        = ctrl;
        steps[row_count].jalr_target = target;
        steps[row_count].pc          = pc;
        steps[row_count].instr       = instr;
        steps[row_count].flags       = flags;
        names[row_count]             = name;
        row_count++;
    endtask

    task automatic load_word(input logic [5:0] word_index, input logic [31:0] word);
        @(negedge clk);
        load_en   = 1'b1;
        load_addr = {word_index, 2'b00};
        load_data = word;
    endtask

    task automatic apply_inputs(input logic write, input step_t s);
        pc_write                          = write;
        {prediction, pc_src, jalr_flag}   = write ? s.ctrl : 3'b000;
        jalr_target                       = s.jalr_target;
    endtask

    task automatic check_instr(input string name, input rv_instr_t expected,
                               input rv_instr_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: instr expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_header(input string name, input fetch_packet_t expected,
                                input fetch_packet_t actual);
        check_count++;
        if (actual.valid !== expected.valid || actual.pc !== expected.pc ||
            actual.compressed !== expected.compressed ||
            actual.decompress_failed !== expected.decompress_failed ||
            actual.is_branch !== expected.is_branch) begin
            error_count++;
            $display("CHECK FAILED %s: expected valid=%b pc=%h c=%b fail=%b br=%b", name,
                     expected.valid, expected.pc, expected.compressed,
                     expected.decompress_failed, expected.is_branch);
            $display("    actual valid=%b pc=%h c=%b fail=%b br=%b", actual.valid, actual.pc,
                     actual.compressed, actual.decompress_failed, actual.is_branch);
        end
    endtask

    task automatic check_flush(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: if_id_flush expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_row(input string name, input step_t s, input logic stalled);
        fetch_packet_t expected;
        expected                   = '0;
        expected.valid             = stalled ? 1'b0 : s.flags[1];
        expected.pc                = s.pc;
        expected.compressed        = s.flags[3];
        expected.decompress_failed = s.flags[2];
        expected.is_branch         = s.flags[4];
        check_header(name, expected, packet);
        // an illegal parcel has no defined expansion
        if (!s.flags[2])
            check_instr(name, s.instr, packet.instr);
        check_flush(name, stalled ? 1'b0 : s.flags[0], if_id_flush);
    endtask

    initial begin
        clk         = 1'b0;
        reset_n     = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        pc_write    = 1'b0;
        prediction  = 1'b0;
        pc_src      = 1'b0;
        jalr_flag   = 1'b0;
        jalr_target = '0;
        void'($urandom(59378));

        add_row("addi_word0",         3'b000, 32'h0, 32'h0000_0000, 32'h0050_0093, 5'b00010);
        add_row("c_li",               3'b000, 32'h0, 32'h0000_0004, 32'h0030_0513, 5'b01010);
        add_row("add_straddle",       3'b000, 32'h0, 32'h0000_0006, 32'h0020_81B3, 5'b00010);
        add_row("c_addi",             3'b000, 32'h0, 32'h0000_000A, 32'hFFF4_0413, 5'b01010);
        add_row("jal_taken",          3'b000, 32'h0, 32'h0000_000C, 32'h00C0_00EF, 5'b00010);
        add_row("beq_pred_taken",     3'b100, 32'h0, 32'h0000_0018, 32'h0000_0463, 5'b10010);
        add_row("c_bnez_pred_not",    3'b000, 32'h0, 32'h0000_0020, 32'h0004_1863, 5'b11010);
        add_row("c_nop_beq_resolved", 3'b010, 32'h0, 32'h0000_0022, 32'h0000_0013, 5'b01010);
        add_row("bnez_mispredict",    3'b010, 32'h0, 32'h0000_0024, 32'h0000_0013, 5'b00001);
        add_row("beq_recovered",      3'b100, 32'h0, 32'h0000_0030, 32'h0220_8063, 5'b10010);
        add_row("illegal_parcel",     3'b000, 32'h0, 32'h0000_0050, 32'h0000_0000, 5'b01110);
        add_row("beq_mispredict",     3'b000, 32'h0, 32'h0000_0052, 32'h0060_02B3, 5'b01001);
        add_row("jalr_fetched",       3'b000, 32'h0, 32'h0000_0034, 32'h0000_8067, 5'b00010);
        add_row("c_lw",               3'b000, 32'h0, 32'h0000_0038, 32'h0045_2483, 5'b01010);
        add_row("c_sw",               3'b000, 32'h0, 32'h0000_003A, 32'h00B6_2423, 5'b01010);
        add_row("jalr_redirect",      3'b001, 32'h58, 32'h0000_003C, 32'h0000_0013, 5'b00001);
        add_row("c_j_at_target",      3'b000, 32'h0, 32'h0000_0058, 32'h0080_006F, 5'b01010);
        add_row("addi_after_c_j",     3'b000, 32'h0, 32'h0000_0060, 32'h0010_0113, 5'b00010);

        // only the words on the fetched path
        load_word(6'd0,  32'h0050_0093);
        load_word(6'd1,  32'h81B3_450D);
        load_word(6'd2,  32'h147D_0020);
        load_word(6'd3,  32'h00C0_00EF);
        load_word(6'd6,  32'h0000_0463);
        load_word(6'd8,  32'h0001_E801);
        load_word(6'd9,  32'h0000_0013);
        load_word(6'd12, 32'h0220_8063);
        load_word(6'd13, 32'h0000_8067);
        load_word(6'd14, 32'hC60C_4144);
        load_word(6'd15, 32'h0000_0013);
        load_word(6'd20, 32'h829A_0000);
        load_word(6'd22, 32'h0001_A021);
        load_word(6'd24, 32'h0010_0113);
        @(negedge clk);
        load_en = 1'b0;

        // reset stays low for four more cycles after the load
        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        // first edge out of reset only wakes the fetch stage
        @(negedge clk);

        for (int i = 0; i < row_count; i++) begin
            if (i == 2 || $urandom % 3 == 0) begin
                apply_inputs(1'b0, steps[i]);
                #4;
                check_row({names[i], "_stall"}, steps[i], 1'b1);
                @(negedge clk);
            end
            apply_inputs(1'b1, steps[i]);
            #4;
            check_row(names[i], steps[i], 1'b0);
            @(negedge clk);
        end

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+src
src/fetch_pkg.sv
src/instr_rom.sv
src/instr_decompressor.sv
src/fetch_stage.sv
src/fetch_top.sv
tb/fetch_tb.sv

/* run.sh */
#!/bin/bash
# build and run the fetch unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -f all.f --top-module fetch_tb -o fetch_sim \
    && ./obj_dir/fetch_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0
